// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // ------------------------------
    // Sizes and constants
    // ------------------------------
    localparam int ADDR_W    = 32;
    localparam int ISSUE_W   = 4;
    localparam int BUF_DEPTH = 16;
    localparam int LOW_WATER = 8;

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h3000_0000;

    // Derived widths
    localparam int LINE_W = ISSUE_W * 32;
    localparam int OFF_W  = $clog2(ISSUE_W * 4);
    localparam int PTR_W  = $clog2(BUF_DEPTH);

    // ------------------------------
    // Interface types
    // ------------------------------

    // Back end restart request
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
    } redirect_t;

    // Line request, low OFF_W bits of addr always zero
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    // Slot 0 sits in the lowest 32 bits
    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] line;
    } mem_resp_t;

    typedef struct packed {
        logic [31:0]       inst;
        logic [ADDR_W-1:0] pc;
    } inst_slot_t;

    // Fresh line paired with the pc that requested it
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [LINE_W-1:0] line;
    } line_pkt_t;

    // Aligned group of 1 to 4 instructions for the buffer
    typedef struct packed {
        logic                          valid;
        logic [2:0]                    count;
        inst_slot_t [ISSUE_W-1:0]      slots;
    } write_pkt_t;

    typedef inst_slot_t [ISSUE_W-1:0] issue_t;

endpackage

// ==== hdl/pc_gen.sv ====
module pc_gen
    import fetch_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  redirect_t         redirect_i,
    input  logic              advance_i,
    output logic [ADDR_W-1:0] pc_o
);

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] next_line;

    // Start of the following line, drops any slot offset
    assign next_line = {pc_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}} + ADDR_W'(ISSUE_W * 4);

    // ------------------------------
    // PC register
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.valid) begin
            // Redirect target may land mid-line
            pc_q <= redirect_i.pc;
        end else if (advance_i) begin
            pc_q <= next_line;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== hdl/line_fetch.sv ====
module line_fetch
    import fetch_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  redirect_t         redirect_i,
    input  logic [ADDR_W-1:0] pc_i,
    input  logic [4:0]        buf_count_i,
    output mem_req_t          mem_req_o,
    input  mem_resp_t         mem_resp_i,
    output logic              advance_o,
    output line_pkt_t         line_o
);

    logic              outstanding_q;
    logic              stale_q;
    logic [ADDR_W-1:0] req_pc_q;
    logic              issue;

    // ------------------------------
    // Request decision
    // ------------------------------

    // One line in flight at most, and only with room below the low water mark
    assign issue = !outstanding_q && !redirect_i.valid && (buf_count_i <= 5'(LOW_WATER));

    assign mem_req_o.valid = issue;
    assign mem_req_o.addr  = {pc_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign advance_o       = issue;

    // ------------------------------
    // Outstanding request tracking
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            if (mem_resp_i.valid) begin
                outstanding_q <= 1'b0;
                stale_q       <= 1'b0;
            end else if (issue) begin
                outstanding_q <= 1'b1;
            end else if (redirect_i.valid && outstanding_q) begin
                // Pending line belongs to the old stream
                stale_q <= 1'b1;
            end
        end
    end

    // Pc of the request, kept with its slot offset
    always_ff @(posedge clock) begin
        if (issue) begin
            req_pc_q <= pc_i;
        end
    end

    // ------------------------------
    // Response pass-through
    // ------------------------------
    assign line_o.valid = mem_resp_i.valid && !stale_q;
    assign line_o.pc    = req_pc_q;
    assign line_o.line  = mem_resp_i.line;

endmodule

// ==== hdl/slot_align.sv ====
module slot_align
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  redirect_t  redirect_i,
    input  line_pkt_t  line_i,
    output write_pkt_t write_o
);

    logic [OFF_W-3:0]         idx;
    logic [2:0]               count_d;
    inst_slot_t [ISSUE_W-1:0] slots_d;

    logic                     valid_q;
    logic [2:0]               count_q;
    inst_slot_t [ISSUE_W-1:0] slots_q;

    // Slot offset of the requesting pc within its line
    assign idx     = line_i.pc[OFF_W-1:2];
    assign count_d = 3'(ISSUE_W) - {1'b0, idx};

    // ------------------------------
    // Slot selection
    // ------------------------------
    always_comb begin
        for (int k = 0; k < ISSUE_W; k++) begin
            // Slots past count wrap around and are ignored downstream
            slots_d[k].inst = line_i.line[32 * ((int'(idx) + k) % ISSUE_W) +: 32];
            slots_d[k].pc   = line_i.pc + ADDR_W'(4 * k);
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (redirect_i.valid) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= line_i.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (line_i.valid) begin
            count_q <= count_d;
            slots_q <= slots_d;
        end
    end

    assign write_o.valid = valid_q;
    assign write_o.count = count_q;
    assign write_o.slots = slots_q;

endmodule

// ==== hdl/inst_buffer.sv ====
module inst_buffer
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  redirect_t  redirect_i,
    input  write_pkt_t write_i,
    input  logic [2:0] read_count_i,
    output issue_t     issue_o,
    output logic [4:0] count_o
);

    inst_slot_t mem [BUF_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [4:0]       count_q;

    logic             wr_en;
    logic [4:0]       wr_num;
    logic [4:0]       rd_num;

    // A redirect drops the write that arrives with it
    assign wr_en  = write_i.valid && !redirect_i.valid;
    assign wr_num = wr_en ? {2'b00, write_i.count} : 5'd0;
    assign rd_num = {2'b00, read_count_i};

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int k = 0; k < ISSUE_W; k++) begin
                if (3'(k) < write_i.count) begin
                    mem[tail_q + PTR_W'(k)] <= write_i.slots[k];
                end
            end
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (redirect_i.valid) begin
            // Flush everything younger than the redirect
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(read_count_i);
            tail_q  <= tail_q + PTR_W'(wr_num);
            count_q <= count_q + wr_num - rd_num;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // Four oldest entries, slots at or past count are don't care
    always_comb begin
        for (int k = 0; k < ISSUE_W; k++) begin
            issue_o[k] = mem[head_q + PTR_W'(k)];
        end
    end

    assign count_o = count_q;

endmodule

// ==== hdl/fetch_top.sv ====
module fetch_top
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  redirect_t  redirect_i,
    input  logic [2:0] read_count_i,
    output mem_req_t   mem_req_o,
    input  mem_resp_t  mem_resp_i,
    output issue_t     issue_o,
    output logic [4:0] avail_o
);

    logic [ADDR_W-1:0] pc;
    logic              advance;
    line_pkt_t         line_pkt;
    write_pkt_t        write_pkt;
    logic [4:0]        buf_count;

    // ------------------------------
    // Fetch pipeline
    // ------------------------------
    pc_gen u_pc_gen (
        .clock      (clock),
        .reset      (reset),
        .redirect_i (redirect_i),
        .advance_i  (advance),
        .pc_o       (pc)
    );

    line_fetch u_line_fetch (
        .clock       (clock),
        .reset       (reset),
        .redirect_i  (redirect_i),
        .pc_i        (pc),
        .buf_count_i (buf_count),
        .mem_req_o   (mem_req_o),
        .mem_resp_i  (mem_resp_i),
        .advance_o   (advance),
        .line_o      (line_pkt)
    );

    slot_align u_slot_align (
        .clock      (clock),
        .reset      (reset),
        .redirect_i (redirect_i),
        .line_i     (line_pkt),
        .write_o    (write_pkt)
    );

    // Occupancy feeds back to the request throttle
    inst_buffer u_inst_buffer (
        .clock        (clock),
        .reset        (reset),
        .redirect_i   (redirect_i),
        .write_i      (write_pkt),
        .read_count_i (read_count_i),
        .issue_o      (issue_o),
        .count_o      (buf_count)
    );

    assign avail_o = buf_count;

endmodule

// ==== test/clock_gen.sv ====
module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clock_o = 1'b0;
        forever begin
            #10 clock_o = ~clock_o;
        end
    end

    // Held for 8 rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

// ==== test/fetch_sva.sv ====
module fetch_sva
    import fetch_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input redirect_t  redirect_i,
    input logic [2:0] read_count_i,
    input logic [4:0] count_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // Buffer occupancy rules
    // ------------------------------
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count_i <= 5'(BUF_DEPTH))
        else $error("buffer count %0d above depth", count_i);

    a_read_bound: assert property (@(posedge clock) disable iff (reset)
        {2'b00, read_count_i} <= count_i)
        else $error("read of %0d with only %0d entries", read_count_i, count_i);

    // Buffer stays empty for three cycles after a redirect
    // Aligner flush and stale line drop keep older lines out
    a_flush: assert property (@(posedge clock) disable iff (reset)
        (redirect_i.valid || $past(redirect_i.valid) || $past(redirect_i.valid, 2))
            |=> count_i == 5'd0)
        else $error("buffer not empty after redirect, count %0d", count_i);

endmodule

bind inst_buffer fetch_sva sva0 (
    .clock        (clock),
    .reset        (reset),
    .redirect_i   (redirect_i),
    .read_count_i (read_count_i),
    .count_i      (count_q)
);

// ==== test/fetch_tb.sv ====
module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] INST_XOR = 32'hA5A5_0000;

    // One stimulus row
    typedef struct packed {
        logic              redirect;
        logic [ADDR_W-1:0] target;
        logic [15:0]       cycles;
        logic              random_read;
        logic [2:0]        fixed_read;
    } row_t;

    logic       clock;
    logic       reset;
    redirect_t  redirect;
    logic [2:0] read_count;
    mem_req_t   mem_req;
    mem_resp_t  mem_resp;
    issue_t     issue;
    logic [4:0] avail;

    row_t rows [$];
    int   slot_errors;
    int   avail_errors;
    int   req_errors;
    int   other_errors;
    int   cyc;
    int   limit;
    int   watch = 0;
    int   taken;
    int   prev_read;
    logic prev_redirect;
    logic [31:0] rng;

    // Memory model and reference state
    logic              mem_busy;
    logic              mem_stale;
    int                resp_cyc;
    logic [ADDR_W-1:0] mem_addr;
    logic [ADDR_W-1:0] req_pc;
    logic [ADDR_W-1:0] fetch_pc;
    logic [ADDR_W-1:0] exp_pc;
    logic [4:0]        exp_count;
    int                land_cyc_q [$];
    logic [4:0]        land_num_q [$];

    clock_gen clk0 (
        .clock_o (clock),
        .reset_o (reset)
    );

    fetch_top dut0 (
        .clock        (clock),
        .reset        (reset),
        .redirect_i   (redirect),
        .read_count_i (read_count),
        .mem_req_o    (mem_req),
        .mem_resp_i   (mem_resp),
        .issue_o      (issue),
        .avail_o      (avail)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:4], 4'b0000};
    endfunction

    function automatic logic [LINE_W-1:0] make_line(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < ISSUE_W; i++) begin
            line[32 * i +: 32] = (base + ADDR_W'(4 * i)) ^ INST_XOR;
        end
        return line;
    endfunction

    task automatic check_slot(input string name, input inst_slot_t exp, input inst_slot_t act);
        if (act !== exp) begin
            slot_errors++;
            $display("ERR %s: expected inst %h pc %h, got inst %h pc %h",
                     name, exp.inst, exp.pc, act.inst, act.pc);
        end
    endtask

    task automatic check_avail(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            avail_errors++;
            $display("ERR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act.valid !== exp.valid || (exp.valid && act.addr !== exp.addr)) begin
            req_errors++;
            $display("ERR %s: expected valid %h addr %h, got valid %h addr %h",
                     name, exp.valid, exp.addr, act.valid, act.addr);
        end
    endtask

    task automatic add_row(input logic redir, input logic [ADDR_W-1:0] target,
                           input int cycles, input logic random_read, input int fixed_read);
        row_t r;
        r.redirect    = redir;
        r.target      = target;
        r.cycles      = 16'(cycles);
        r.random_read = random_read;
        r.fixed_read  = 3'(fixed_read);
        rows.push_back(r);
    endtask

    task automatic load_table();
        // Straight run from reset with random reads
        add_row(1'b0, '0, 40, 1'b1, 0);
        // Decode stalls, then drains four at a time
        add_row(1'b0, '0, 40, 1'b0, 0);
        add_row(1'b0, '0, 30, 1'b0, 4);
        // Misaligned target in slot 2
        add_row(1'b1, 32'h3000_0108, 30, 1'b1, 0);
        // Back to back redirects hit a line in flight
        add_row(1'b1, 32'h3000_2004, 2, 1'b0, 0);
        add_row(1'b1, 32'h3000_4000, 3, 1'b0, 1);
        add_row(1'b1, 32'h3000_500C, 50, 1'b1, 0);
        add_row(1'b0, '0, 25, 1'b0, 0);
        add_row(1'b0, '0, 40, 1'b0, 3);
        add_row(1'b1, 32'h3000_6008, 1, 1'b0, 0);
        add_row(1'b1, 32'h3000_7004, 40, 1'b1, 0);
        add_row(1'b0, '0, 30, 1'b0, 2);
    endtask

    // ------------------------------
    // One cycle, entered on a falling edge
    // ------------------------------
    task automatic step_cycle(input logic do_redirect, input logic [ADDR_W-1:0] target,
                              input logic random_read, input logic [2:0] fixed_read);
        int         n;
        int         room;
        logic       resp_now;
        inst_slot_t exp_slot;
        mem_req_t   exp_req;

        cyc++;
        // Occupancy after the last rising edge
        if (prev_redirect) begin
            exp_count = 5'd0;
        end else begin
            exp_count = exp_count - 5'(prev_read);
            while (land_cyc_q.size() > 0 && land_cyc_q[0] == cyc) begin
                exp_count = exp_count + land_num_q[0];
                void'(land_cyc_q.pop_front());
                void'(land_num_q.pop_front());
            end
        end
        check_avail("avail_o", exp_count, avail);

        // Decode takes n oldest entries
        room = (avail > 5'd4) ? 4 : int'(avail);
        if (do_redirect) begin
            n = 0;
        end else if (random_read) begin
            rng = xorshift32(rng);
            n = (room == 0) ? 0 : 1 + int'(rng % 32'(room));
        end else begin
            n = (int'(fixed_read) < room) ? int'(fixed_read) : room;
        end
        for (int k = 0; k < n; k++) begin
            exp_slot.inst = exp_pc ^ INST_XOR;
            exp_slot.pc   = exp_pc;
            check_slot($sformatf("issue_o[%0d]", k), exp_slot, issue[k]);
            exp_pc = exp_pc + 32'd4;
            taken++;
        end

        // Memory answer for the line in flight
        resp_now       = mem_busy && (cyc == resp_cyc);
        mem_resp.valid = resp_now;
        mem_resp.line  = resp_now ? make_line(mem_addr) : '0;
        if (resp_now && !mem_stale) begin
            land_cyc_q.push_back(cyc + 2);
            land_num_q.push_back(5'd4 - {3'b000, req_pc[3:2]});
        end

        redirect.valid = do_redirect;
        redirect.pc    = do_redirect ? target : '0;
        read_count     = 3'(n);
        if (do_redirect) begin
            fetch_pc = target;
            exp_pc   = target;
            if (mem_busy) begin
                mem_stale = 1'b1;
            end
            land_cyc_q.delete();
            land_num_q.delete();
        end

        // Request output settles on this cycle's inputs
        #1;
        exp_req.valid = !mem_busy && !do_redirect && (exp_count <= 5'(LOW_WATER));
        exp_req.addr  = line_base(fetch_pc);
        check_req("mem_req_o", exp_req, mem_req);

        if (resp_now) begin
            mem_busy = 1'b0;
        end
        if (mem_req.valid) begin
            rng       = xorshift32(rng);
            mem_busy  = 1'b1;
            mem_stale = 1'b0;
            mem_addr  = mem_req.addr;
            resp_cyc  = cyc + 1 + int'(rng % 32'd4);
        end
        if (exp_req.valid) begin
            req_pc   = fetch_pc;
            fetch_pc = line_base(fetch_pc) + 32'd16;
        end
        prev_read     = n;
        prev_redirect = do_redirect;
        @(negedge clock);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        redirect      = '0;
        read_count    = '0;
        mem_resp      = '0;
        slot_errors   = 0;
        avail_errors  = 0;
        req_errors    = 0;
        other_errors  = 0;
        cyc           = 0;
        taken         = 0;
        prev_read     = 0;
        prev_redirect = 1'b0;
        rng           = 32'd33711;
        mem_busy      = 1'b0;
        mem_stale     = 1'b0;
        resp_cyc      = 0;
        mem_addr      = '0;
        req_pc        = RESET_PC;
        fetch_pc      = RESET_PC;
        exp_pc        = RESET_PC;
        exp_count     = '0;
        load_table();
        limit = 200;
        foreach (rows[i]) begin
            limit += int'(rows[i].cycles);
        end

        @(negedge reset);
        foreach (rows[i]) begin
            for (int c = 0; c < int'(rows[i].cycles); c++) begin
                step_cycle(rows[i].redirect && (c == 0), rows[i].target,
                           rows[i].random_read, rows[i].fixed_read);
            end
        end

        if (taken == 0) begin
            other_errors++;
            $display("No instruction was ever taken from the buffer");
        end
        $display("Errors: slot %0d, avail %0d, request %0d, other %0d",
                 slot_errors, avail_errors, req_errors, other_errors);
        if (slot_errors + avail_errors + req_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clock) begin
        if (!reset) begin
            watch <= watch + 1;
            if (watch >= limit) begin
                other_errors++;
                $display("Timeout: run went past %0d cycles", limit);
                $display("Errors: slot %0d, avail %0d, request %0d, other %0d",
                         slot_errors, avail_errors, req_errors, other_errors);
                $display("Test failures found");
                $finish;
            end
        end
    end

endmodule

// ==== all.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/line_fetch.sv
hdl/slot_align.sv
hdl/inst_buffer.sv
hdl/fetch_top.sv
test/clock_gen.sv
test/fetch_sva.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -f all.f -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
